/* Makefile */
VERILATOR ?= verilator
TOP       ?= breakout_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All checks passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$($(abspath $(SIM)))"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* common/breakout_pkg.sv */
// Shared types, colours and playfield geometry, imported by every RTL block of the game
package breakout_pkg;

	typedef logic [7:0] coord_t;
	typedef logic [2:0] colour_t;  // R, G, B
	typedef logic [3:0] brick_idx_t;

	typedef enum logic [1:0] {
		SHAPE_PADDLE,
		SHAPE_BALL,
		SHAPE_BRICK,
		SHAPE_SCREEN
	} shape_t;

	localparam colour_t COL_BLACK = 3'b000;
	localparam colour_t COL_WHITE = 3'b111;
	localparam colour_t COL_GREEN = 3'b010;
	localparam colour_t COL_RED   = 3'b100;

	localparam coord_t SCREEN_W = 8'd160;
	localparam coord_t SCREEN_H = 8'd120;

	localparam coord_t PADDLE_W     = 8'd16;
	localparam coord_t PADDLE_H     = 8'd2;
	localparam coord_t PADDLE_X0    = 8'd76;
	localparam coord_t PADDLE_Y     = 8'd110;  // Paddle never leaves this row
	localparam coord_t PADDLE_X_MAX = 8'd144;

	localparam coord_t BALL_X0 = 8'd80;
	localparam coord_t BALL_Y0 = 8'd108;

	localparam coord_t BRICK_W    = 8'd8;
	localparam coord_t BRICK_H    = 8'd2;
	localparam int     NUM_BRICKS = 10;

	localparam coord_t BRICK_X [0:4] = '{8'd15, 8'd45, 8'd75, 8'd105, 8'd135};
	localparam coord_t BRICK_Y [0:1] = '{8'd30, 8'd40};

	// Brick i sits in column i mod 5, row i div 5
	function automatic coord_t brick_x(input brick_idx_t idx);
		return (idx >= 4'd5) ? BRICK_X[3'(idx - 4'd5)] : BRICK_X[3'(idx)];
	endfunction

	function automatic coord_t brick_y(input brick_idx_t idx);
		return (idx >= 4'd5) ? BRICK_Y[1] : BRICK_Y[0];
	endfunction

endpackage

/* game/brick_wall.sv */
// Alive flags of the ten bricks and the hit test of the selected brick against the ball
`timescale 1ns/1ps

module brick_wall (
	input  logic                                CLOCK_50,
	input  logic                                arst_n,
	input  logic                                brick_check,
	input  breakout_pkg::brick_idx_t            brick_sel,
	input  breakout_pkg::coord_t                ball_x,
	input  breakout_pkg::coord_t                ball_y,
	output logic                                brick_hit,
	output logic [breakout_pkg::NUM_BRICKS-1:0] brick_alive
);
	import breakout_pkg::*;

	coord_t bx;
	coord_t by;
	logic   in_box;

	assign bx = brick_x(brick_sel);
	assign by = brick_y(brick_sel);

	assign in_box = ball_x >= bx && ball_x <= bx + BRICK_W - 8'd1
		&& ball_y >= by && ball_y <= by + BRICK_H - 8'd1;

	assign brick_hit = brick_check && brick_alive[brick_sel] && in_box;

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n)
			brick_alive <= '1;
		else if (brick_hit)
			brick_alive[brick_sel] <= 1'b0;  // Gone for good
	end

	a_sel_range: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		brick_check |-> brick_sel < NUM_BRICKS);

endmodule

/* game/game_fsm.sv */
// Game sequencer, runs the start-up drawing, each frame's erase, step and redraw, and the red fill
`timescale 1ns/1ps

module game_fsm (
	input  logic                                CLOCK_50,
	input  logic                                arst_n,
	input  logic                                tick,
	input  logic                                plot_done,
	input  logic                                ball_dead,
	input  breakout_pkg::coord_t                paddle_x,
	input  breakout_pkg::coord_t                ball_x,
	input  breakout_pkg::coord_t                ball_y,
	input  logic [breakout_pkg::NUM_BRICKS-1:0] brick_alive,
	output logic                                paddle_step,
	output logic                                ball_step,
	output logic                                brick_check,
	output breakout_pkg::brick_idx_t            brick_sel,
	output logic                                plot_start,
	output breakout_pkg::shape_t                plot_shape,
	output breakout_pkg::coord_t                plot_x,
	output breakout_pkg::coord_t                plot_y,
	output breakout_pkg::colour_t               plot_colour
);
	import breakout_pkg::*;

	typedef enum logic [3:0] {
		S_CLEAR, S_INIT_PADDLE, S_INIT_BALL, S_INIT_BRICK,
		S_IDLE, S_ERASE_PADDLE, S_STEP_PADDLE, S_DRAW_PADDLE,
		S_ERASE_BALL, S_STEP_BALL, S_TEST_BALL, S_DRAW_BALL,
		S_CHECK_BRICK, S_DRAW_BRICK, S_FILL_RED, S_DEAD
	} state_t;

	state_t state;
	logic   issued;  // Plot request out, waiting for done
	logic   drawing;
	logic   draw_done;
	logic   last_brick;

	assign drawing = state inside {S_CLEAR, S_INIT_PADDLE, S_INIT_BALL, S_INIT_BRICK,
		S_ERASE_PADDLE, S_DRAW_PADDLE, S_ERASE_BALL, S_DRAW_BALL, S_DRAW_BRICK, S_FILL_RED};
	assign draw_done  = issued && plot_done;
	assign last_brick = brick_sel == brick_idx_t'(NUM_BRICKS - 1);

	assign paddle_step = state == S_STEP_PADDLE;
	assign ball_step   = state == S_STEP_BALL;
	assign brick_check = state == S_CHECK_BRICK;

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			state      <= S_CLEAR;
			issued     <= 1'b0;
			plot_start <= 1'b0;
			brick_sel  <= '0;
		end else begin
			plot_start <= 1'b0;
			if (drawing && !issued) begin
				plot_start <= 1'b1;
				issued     <= 1'b1;
			end
			if (draw_done)
				issued <= 1'b0;

			case (state)
				S_CLEAR:        if (draw_done) state <= S_INIT_PADDLE;
				S_INIT_PADDLE:  if (draw_done) state <= S_INIT_BALL;
				S_INIT_BALL:    if (draw_done) state <= S_INIT_BRICK;
				S_INIT_BRICK: begin
					if (draw_done) begin
						brick_sel <= last_brick ? '0 : brick_sel + 4'd1;
						if (last_brick)
							state <= S_IDLE;
					end
				end
				S_IDLE:         if (tick) state <= S_ERASE_PADDLE;  // Late ticks are dropped
				S_ERASE_PADDLE: if (draw_done) state <= S_STEP_PADDLE;
				S_STEP_PADDLE:  state <= S_DRAW_PADDLE;
				S_DRAW_PADDLE:  if (draw_done) state <= S_ERASE_BALL;
				S_ERASE_BALL:   if (draw_done) state <= S_STEP_BALL;
				S_STEP_BALL:    state <= S_TEST_BALL;
				S_TEST_BALL:    state <= ball_dead ? S_FILL_RED : S_DRAW_BALL;
				S_DRAW_BALL:    if (draw_done) state <= S_CHECK_BRICK;
				S_CHECK_BRICK:  state <= S_DRAW_BRICK;
				S_DRAW_BRICK: begin
					if (draw_done) begin
						brick_sel <= last_brick ? '0 : brick_sel + 4'd1;
						state     <= last_brick ? S_IDLE : S_CHECK_BRICK;
					end
				end
				S_FILL_RED:     if (draw_done) state <= S_DEAD;
				default:        state <= S_DEAD;  // Stays until reset
			endcase
		end
	end

	always_comb begin
		plot_shape  = SHAPE_SCREEN;
		plot_x      = 8'd0;
		plot_y      = 8'd0;
		plot_colour = COL_BLACK;
		case (state)
			S_INIT_PADDLE, S_ERASE_PADDLE, S_DRAW_PADDLE: begin
				plot_shape  = SHAPE_PADDLE;
				plot_x      = paddle_x;
				plot_y      = PADDLE_Y;
				plot_colour = (state == S_ERASE_PADDLE) ? COL_BLACK : COL_WHITE;
			end
			S_INIT_BALL, S_ERASE_BALL, S_DRAW_BALL: begin
				plot_shape  = SHAPE_BALL;
				plot_x      = ball_x;
				plot_y      = ball_y;
				plot_colour = (state == S_ERASE_BALL) ? COL_BLACK : COL_WHITE;
			end
			S_INIT_BRICK, S_DRAW_BRICK: begin
				plot_shape  = SHAPE_BRICK;
				plot_x      = brick_x(brick_sel);
				plot_y      = brick_y(brick_sel);
				plot_colour = brick_alive[brick_sel] ? COL_GREEN : COL_BLACK;
			end
			S_FILL_RED: plot_colour = COL_RED;
			default: ;
		endcase
	end

endmodule

/* game/play_motion.sv */
// Paddle and ball state, one step of movement and bouncing per pulse from the game sequencer
`timescale 1ns/1ps

module play_motion (
	input  logic                 CLOCK_50,
	input  logic                 arst_n,
	input  logic                 btn_right_n,
	input  logic                 btn_left_n,
	input  logic                 paddle_step,
	input  logic                 ball_step,
	input  logic                 brick_hit,
	output breakout_pkg::coord_t paddle_x,
	output breakout_pkg::coord_t ball_x,
	output breakout_pkg::coord_t ball_y,
	output logic                 ball_dead
);
	import breakout_pkg::*;

	logic   x_right;
	logic   y_down;
	logic   flip_x;
	logic   flip_y;
	coord_t paddle_next;
	coord_t ball_nx;
	coord_t ball_ny;

	always_comb begin
		paddle_next = paddle_x;
		if (!btn_right_n && paddle_next < PADDLE_X_MAX)
			paddle_next = paddle_next + 8'd1;
		if (!btn_left_n && paddle_next > 8'd0)
			paddle_next = paddle_next - 8'd1;
	end

	assign ball_nx = x_right ? ball_x + 8'd1 : ball_x - 8'd1;
	assign ball_ny = y_down ? ball_y + 8'd1 : ball_y - 8'd1;

	assign flip_x = (ball_nx == 8'd0) || (ball_nx == SCREEN_W - 8'd1);
	assign flip_y = (ball_ny == 8'd0)
		|| (y_down && ball_ny == PADDLE_Y - 8'd1
			&& ball_nx >= paddle_x && ball_nx <= paddle_x + PADDLE_W - 8'd1);  // Paddle top

	assign ball_dead = ball_y >= SCREEN_H - 8'd1;

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			paddle_x <= PADDLE_X0;
			ball_x   <= BALL_X0;
			ball_y   <= BALL_Y0;
			x_right  <= 1'b1;
			y_down   <= 1'b0;  // Launch upwards
		end else begin
			if (paddle_step)
				paddle_x <= paddle_next;
			if (ball_step) begin
				ball_x  <= ball_nx;
				ball_y  <= ball_ny;
				x_right <= x_right ^ flip_x;
				y_down  <= y_down ^ flip_y;
			end else if (brick_hit) begin
				y_down <= ~y_down;
			end
		end
	end

endmodule

/* logic/breakout_top.sv */
// Playfield engine top level, wires the frame tick, sequencer, motion, bricks and pixel plotter
`timescale 1ns/1ps

module breakout_top #(
	parameter int FRAME_CYCLES = 833_333
) (
	input  logic                  CLOCK_50,
	input  logic                  arst_n,
	input  logic                  btn_right_n,
	input  logic                  btn_left_n,
	input  logic                  pixel_ready,
	output logic                  pixel_valid,
	output breakout_pkg::coord_t  pixel_x,
	output breakout_pkg::coord_t  pixel_y,
	output breakout_pkg::colour_t pixel_colour
);
	import breakout_pkg::*;

	logic                  tick;
	logic                  paddle_step;
	logic                  ball_step;
	logic                  ball_dead;
	logic                  brick_check;
	logic                  brick_hit;
	logic [NUM_BRICKS-1:0] brick_alive;
	brick_idx_t            brick_sel;
	coord_t                paddle_x;
	coord_t                ball_x;
	coord_t                ball_y;
	logic                  plot_start;
	logic                  plot_done;
	shape_t                plot_shape;
	coord_t                plot_x;
	coord_t                plot_y;
	colour_t               plot_colour;

	frame_tick #(
		.FRAME_CYCLES(FRAME_CYCLES)
	) tick_i (
		.CLOCK_50(CLOCK_50),
		.arst_n  (arst_n),
		.tick    (tick)
	);

	game_fsm fsm_i (
		.CLOCK_50   (CLOCK_50),
		.arst_n     (arst_n),
		.tick       (tick),
		.plot_done  (plot_done),
		.ball_dead  (ball_dead),
		.paddle_x   (paddle_x),
		.ball_x     (ball_x),
		.ball_y     (ball_y),
		.brick_alive(brick_alive),
		.paddle_step(paddle_step),
		.ball_step  (ball_step),
		.brick_check(brick_check),
		.brick_sel  (brick_sel),
		.plot_start (plot_start),
		.plot_shape (plot_shape),
		.plot_x     (plot_x),
		.plot_y     (plot_y),
		.plot_colour(plot_colour)
	);

	play_motion motion_i (
		.CLOCK_50   (CLOCK_50),
		.arst_n     (arst_n),
		.btn_right_n(btn_right_n),
		.btn_left_n (btn_left_n),
		.paddle_step(paddle_step),
		.ball_step  (ball_step),
		.brick_hit  (brick_hit),
		.paddle_x   (paddle_x),
		.ball_x     (ball_x),
		.ball_y     (ball_y),
		.ball_dead  (ball_dead)
	);

	brick_wall bricks_i (
		.CLOCK_50   (CLOCK_50),
		.arst_n     (arst_n),
		.brick_check(brick_check),
		.brick_sel  (brick_sel),
		.ball_x     (ball_x),
		.ball_y     (ball_y),
		.brick_hit  (brick_hit),
		.brick_alive(brick_alive)
	);

	rect_plotter plotter_i (
		.CLOCK_50    (CLOCK_50),
		.arst_n      (arst_n),
		.plot_start  (plot_start),
		.plot_shape  (plot_shape),
		.plot_x      (plot_x),
		.plot_y      (plot_y),
		.plot_colour (plot_colour),
		.plot_done   (plot_done),
		.pixel_ready (pixel_ready),
		.pixel_valid (pixel_valid),
		.pixel_x     (pixel_x),
		.pixel_y     (pixel_y),
		.pixel_colour(pixel_colour)
	);

endmodule

/* logic/frame_tick.sv */
// Game pacing counter, pulses tick for one clock every FRAME_CYCLES clocks to start a frame
`timescale 1ns/1ps

module frame_tick #(
	parameter int FRAME_CYCLES = 833_333
) (
	input  logic CLOCK_50,
	input  logic arst_n,
	output logic tick
);

	localparam int CW = $clog2(FRAME_CYCLES);

	logic [CW-1:0] count;

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			count <= CW'(FRAME_CYCLES - 1);
			tick  <= 1'b0;
		end else if (count == '0) begin
			count <= CW'(FRAME_CYCLES - 1);  // Reload
			tick  <= 1'b1;
		end else begin
			count <= count - CW'(1);
			tick  <= 1'b0;
		end
	end

	a_tick_single: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		tick |=> !tick);

endmodule

/* logic/rect_plotter.sv */
// Rectangle walker, turns one plot request into a row-major valid/ready pixel stream
`timescale 1ns/1ps

module rect_plotter (
	input  logic                  CLOCK_50,
	input  logic                  arst_n,
	input  logic                  plot_start,
	input  breakout_pkg::shape_t  plot_shape,
	input  breakout_pkg::coord_t  plot_x,
	input  breakout_pkg::coord_t  plot_y,
	input  breakout_pkg::colour_t plot_colour,
	output logic                  plot_done,
	input  logic                  pixel_ready,
	output logic                  pixel_valid,
	output breakout_pkg::coord_t  pixel_x,
	output breakout_pkg::coord_t  pixel_y,
	output breakout_pkg::colour_t pixel_colour
);
	import breakout_pkg::*;

	coord_t  size_w;
	coord_t  size_h;
	coord_t  org_x;
	coord_t  org_y;
	coord_t  last_col;
	coord_t  last_row;
	coord_t  col;
	coord_t  row;
	colour_t colour;
	logic    xfer;

	always_comb begin
		case (plot_shape)
			SHAPE_PADDLE: begin
				size_w = PADDLE_W;
				size_h = PADDLE_H;
			end
			SHAPE_BALL: begin
				size_w = 8'd1;  // Single pixel
				size_h = 8'd1;
			end
			SHAPE_BRICK: begin
				size_w = BRICK_W;
				size_h = BRICK_H;
			end
			default: begin
				size_w = SCREEN_W;
				size_h = SCREEN_H;
			end
		endcase
	end

	always_ff @(posedge CLOCK_50) begin
		if (plot_start) begin
			org_x    <= (plot_shape == SHAPE_SCREEN) ? 8'd0 : plot_x;
			org_y    <= (plot_shape == SHAPE_SCREEN) ? 8'd0 : plot_y;
			last_col <= size_w - 8'd1;
			last_row <= size_h - 8'd1;
			colour   <= plot_colour;
		end
	end

	assign xfer = pixel_valid && pixel_ready;

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			pixel_valid <= 1'b0;
			plot_done   <= 1'b0;
			col         <= '0;
			row         <= '0;
		end else begin
			plot_done <= 1'b0;
			if (plot_start) begin
				pixel_valid <= 1'b1;
				col         <= '0;
				row         <= '0;
			end else if (xfer) begin
				if (col != last_col) begin
					col <= col + 8'd1;
				end else begin
					col <= '0;
					if (row != last_row) begin
						row <= row + 8'd1;
					end else begin
						pixel_valid <= 1'b0;  // Last pixel gone
						plot_done   <= 1'b1;
					end
				end
			end
		end
	end

	assign pixel_x      = org_x + col;
	assign pixel_y      = org_y + row;
	assign pixel_colour = colour;

	a_stall_stable: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		pixel_valid && !pixel_ready |=> pixel_valid && $stable(pixel_x)
			&& $stable(pixel_y) && $stable(pixel_colour));

endmodule

/* tests/breakout_golden.txt */
// Per frame: btn_right_n btn_left_n, then paddle x, ball x, ball y after that frame
// Hex values, buttons are active low
0 1 4d 51 6b
0 1 4e 52 6a
0 1 4f 53 69
0 1 50 54 68
1 0 4f 55 67
1 0 4e 56 66
1 0 4d 57 65
0 0 4d 58 64
1 1 4d 59 63
1 1 4d 5a 62
0 1 4e 5b 61
0 1 4f 5c 60

/* tests/breakout_tb.sv */
// Self-checking testbench for breakout_top, replays the golden frames and then plays the game to its end
`timescale 1ns/1ps

module breakout_tb;
	import breakout_pkg::*;

	localparam int FRAME_CYCLES  = 1000;
	localparam int GOLDEN_LINES  = 12;
	localparam int GW            = $clog2(GOLDEN_LINES * 5);
	localparam int PIXEL_TIMEOUT = 4 * FRAME_CYCLES;
	localparam int MAX_FRAMES    = 400;

	logic    CLOCK_50 = 1'b0;
	logic    arst_n;
	logic    btn_right_n;
	logic    btn_left_n;
	logic    pixel_ready;
	logic    pixel_valid;
	coord_t  pixel_x;
	coord_t  pixel_y;
	colour_t pixel_colour;

	logic [7:0] golden [0:GOLDEN_LINES*5-1];
	integer     seed = 12;
	logic       stalled;
	coord_t     held_x;
	coord_t     held_y;
	colour_t    held_c;

	coord_t                m_pad;  // Reference model
	coord_t                m_bx;
	coord_t                m_by;
	logic                  m_right;
	logic                  m_down;
	logic [NUM_BRICKS-1:0] m_alive;
	int                    hits;

	breakout_top #(
		.FRAME_CYCLES(FRAME_CYCLES)
	) dut_i (
		.CLOCK_50    (CLOCK_50),
		.arst_n      (arst_n),
		.btn_right_n (btn_right_n),
		.btn_left_n  (btn_left_n),
		.pixel_ready (pixel_ready),
		.pixel_valid (pixel_valid),
		.pixel_x     (pixel_x),
		.pixel_y     (pixel_y),
		.pixel_colour(pixel_colour)
	);

	always #4 CLOCK_50 = ~CLOCK_50;

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("Checks failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_pixel(input string what, input coord_t gx, input coord_t gy,
		input colour_t gc, input coord_t ex, input coord_t ey, input colour_t ec);
		if (gx !== ex || gy !== ey || gc !== ec)
			stop_run($sformatf("error at %0t ns: %s is (%0d,%0d,%0d), expected (%0d,%0d,%0d)",
				$time, what, gx, gy, gc, ex, ey, ec));
	endtask

	task automatic check_position(input string what, input coord_t got, input coord_t exp);
		if (got !== exp)
			stop_run($sformatf("error at %0t ns: %s is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	task automatic check_colour(input string what, input colour_t got, input colour_t exp);
		if (got !== exp)
			stop_run($sformatf("error at %0t ns: %s is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	// Drives ready on each falling edge and predicts the transfer at the next rising edge
	task automatic next_pixel(output coord_t x, output coord_t y, output colour_t c);
		int   waited;
		logic got;
		waited = 0;
		got    = 1'b0;
		while (!got) begin
			if (waited == PIXEL_TIMEOUT)
				stop_run("timeout while waiting for a pixel transfer");
			@(negedge CLOCK_50);
			waited++;
			if (stalled) begin
				if (!pixel_valid)
					stop_run("pixel_valid dropped while a pixel was stalled");
				check_pixel("stalled pixel", pixel_x, pixel_y, pixel_colour,
					held_x, held_y, held_c);
			end
			pixel_ready = (($random(seed) & 3) != 0);  // Low one cycle in four
			got     = pixel_valid && pixel_ready;
			stalled = pixel_valid && !pixel_ready;
			x       = pixel_x;
			y       = pixel_y;
			c       = pixel_colour;
			held_x  = pixel_x;
			held_y  = pixel_y;
			held_c  = pixel_colour;
		end
	endtask

	task automatic expect_rect(input string what, input coord_t x0, input coord_t y0,
		input coord_t w, input coord_t h, input colour_t col);
		coord_t  x;
		coord_t  y;
		colour_t c;
		for (int r = 0; r < int'(h); r++) begin
			for (int k = 0; k < int'(w); k++) begin
				next_pixel(x, y, c);
				check_position({what, " x"}, x, x0 + coord_t'(k));
				check_position({what, " y"}, y, y0 + coord_t'(r));
				check_colour({what, " colour"}, c, col);
			end
		end
	endtask

	task automatic move_ball();
		m_bx = m_right ? m_bx + 8'd1 : m_bx - 8'd1;
		m_by = m_down ? m_by + 8'd1 : m_by - 8'd1;
		if (m_bx == 8'd0 || m_bx == SCREEN_W - 8'd1)
			m_right = !m_right;
		if (m_by == 8'd0)
			m_down = 1'b1;  // Top wall
		else if (m_down && m_by == PADDLE_Y - 8'd1 && m_bx >= m_pad && m_bx < m_pad + PADDLE_W)
			m_down = 1'b0;
	endtask

	task automatic check_brick(input int b);
		coord_t bx0;
		coord_t by0;
		bx0 = BRICK_X[3'(b % 5)];
		by0 = BRICK_Y[1'(b / 5)];
		if (m_alive[brick_idx_t'(b)] && m_bx >= bx0 && m_bx < bx0 + BRICK_W
			&& m_by >= by0 && m_by < by0 + BRICK_H) begin
			m_alive[brick_idx_t'(b)] = 1'b0;
			m_down = !m_down;
			hits++;
		end
		expect_rect("brick", bx0, by0, BRICK_W, BRICK_H,
			m_alive[brick_idx_t'(b)] ? COL_GREEN : COL_BLACK);
	endtask

	task automatic play_frame(input int n, output logic dead);
		logic right_n;
		logic left_n;
		int   target;
		target = int'(m_bx) - 8;
		if (n <= GOLDEN_LINES) begin
			right_n = golden[GW'(5 * (n - 1))][0];
			left_n  = golden[GW'(5 * (n - 1) + 1)][0];
		end else if (hits == 0) begin
			right_n = !(int'(m_pad) < target);  // Chase the ball
			left_n  = !(int'(m_pad) > target);
		end else begin
			right_n = 1'b1;
			left_n  = 1'b1;
		end
		btn_right_n = right_n;
		btn_left_n  = left_n;
		expect_rect("paddle erase", m_pad, PADDLE_Y, PADDLE_W, PADDLE_H, COL_BLACK);
		if (!right_n && m_pad < PADDLE_X_MAX)
			m_pad = m_pad + 8'd1;
		if (!left_n && m_pad > 8'd0)
			m_pad = m_pad - 8'd1;
		expect_rect("paddle draw", m_pad, PADDLE_Y, PADDLE_W, PADDLE_H, COL_WHITE);
		expect_rect("ball erase", m_bx, m_by, 8'd1, 8'd1, COL_BLACK);
		move_ball();
		if (n <= GOLDEN_LINES) begin
			check_position("golden paddle x", m_pad, golden[GW'(5 * (n - 1) + 2)]);
			check_position("golden ball x", m_bx, golden[GW'(5 * (n - 1) + 3)]);
			check_position("golden ball y", m_by, golden[GW'(5 * (n - 1) + 4)]);
		end
		dead = m_by >= SCREEN_H - 8'd1;
		if (dead) begin
			expect_rect("red fill", 8'd0, 8'd0, SCREEN_W, SCREEN_H, COL_RED);
		end else begin
			expect_rect("ball draw", m_bx, m_by, 8'd1, 8'd1, COL_WHITE);
			for (int b = 0; b < NUM_BRICKS; b++)
				check_brick(b);
		end
	endtask

	task automatic expect_silence();
		for (int k = 0; k < 5 * FRAME_CYCLES; k++) begin
			@(negedge CLOCK_50);
			if (pixel_valid)
				stop_run("pixel_valid rose again after the red fill");
		end
	endtask

	initial begin
		int   frame;
		logic dead;
		arst_n      = 1'b0;
		btn_right_n = 1'b1;
		btn_left_n  = 1'b1;
		pixel_ready = 1'b0;
		stalled     = 1'b0;
		$readmemh("tests/breakout_golden.txt", golden);
		m_pad   = PADDLE_X0;
		m_bx    = BALL_X0;
		m_by    = BALL_Y0;
		m_right = 1'b1;
		m_down  = 1'b0;
		m_alive = '1;
		hits    = 0;
		repeat (5) @(negedge CLOCK_50);
		if (pixel_valid)
			stop_run("pixel_valid is high during reset");
		arst_n = 1'b1;

		expect_rect("clear", 8'd0, 8'd0, SCREEN_W, SCREEN_H, COL_BLACK);
		expect_rect("start paddle", m_pad, PADDLE_Y, PADDLE_W, PADDLE_H, COL_WHITE);
		expect_rect("start ball", m_bx, m_by, 8'd1, 8'd1, COL_WHITE);
		for (int b = 0; b < NUM_BRICKS; b++)
			check_brick(b);

		frame = 0;
		dead  = 1'b0;
		while (!dead) begin
			if (frame == MAX_FRAMES)
				stop_run("the ball never reached the bottom row");
			frame++;
			play_frame(frame, dead);
		end
		expect_silence();
		if (hits == 0)
			stop_run("the game ended without any brick being hit");
		$display("All checks passed");
		$finish;
	end

endmodule

/* verilog.f */
common/breakout_pkg.sv
logic/frame_tick.sv
logic/rect_plotter.sv
game/play_motion.sv
game/brick_wall.sv
game/game_fsm.sv
logic/breakout_top.sv
tests/breakout_tb.sv
